//--- ddr3_slave_golden.txt
# op id addr len burst data_base strb exp_resp exp_base, all hex except op (W or R)
# burst 0 fixed 1 incr 2 wrap; resp 0 okay 2 slverr; len is beats minus one
W 1 00000000 00 1 10000000 f 0 00000000
W 2 00000040 0f 1 20000000 f 0 00000000
W 3 00000400 ff 1 30000000 f 0 00000000
R 1 00000000 00 1 00000000 0 0 10000000
R 2 00000040 0f 1 00000000 0 0 20000000
R 3 00000400 ff 1 00000000 0 0 30000000
W 4 00000100 00 1 a1b2c3d4 f 0 00000000
W 4 00000100 00 1 11223344 5 0 00000000
R 5 00000100 00 1 00000000 0 0 a122c344
W 6 00000200 07 0 50000000 f 0 00000000
R 7 00000200 03 0 00000000 0 0 50000007
W 8 00000fe0 07 1 60000000 f 0 00000000
W 9 00000ff0 07 1 70000000 f 2 00000000
W a 00000040 03 2 80000000 f 2 00000000
R b 00000ff0 07 1 00000000 0 2 00000000
R c 00000040 03 2 00000000 0 2 00000000
R d 00000fe0 07 1 00000000 0 0 60000000
R e 00000040 0f 1 00000000 0 0 20000000

//--- all.f
ddr_slave_pkg.sv
ddr_init_refresh_timer.sv
ddr_slave_fsm.sv
ddr_burst_addr_gen.sv
ddr_mem_array.sv
ddr_rd_data_path.sv
slave_ddr3.sv
ddr3_slave_tb.sv

//--- ddr3_slave_tb.sv
`timescale 1ns/1ps

module ddr3_slave_tb;

    import ddr_slave_pkg::*;

    localparam int MEM_AW      = 10;
    localparam int INIT_CYCLES = 20;
    localparam int WAIT_LIMIT  = 200;  // cycles per handshake

    logic       ddr_ref_clk = 1'b0;
    logic       rst_n;
    axi_id_t    wr_addr_id, wr_back_id, rd_addr_id, rd_back_id;
    axi_addr_t  wr_addr, rd_addr;
    axi_len_t   wr_addr_len, rd_addr_len;
    axi_burst_t wr_addr_burst, rd_addr_burst;
    axi_data_t  wr_data, rd_data;
    axi_strb_t  wr_strb;
    axi_resp_t  wr_back_resp, rd_data_resp;
    logic       wr_addr_valid, wr_addr_ready, wr_data_last, wr_data_valid, wr_data_ready;
    logic       wr_back_valid, wr_back_ready, rd_addr_valid, rd_addr_ready;
    logic       rd_data_last, rd_data_valid, rd_data_ready, init_done;

    axi_data_t shadow [1 << MEM_AW];  // expected array contents
    int        errors = 0;
    int        errors_before = 0;
    int        tests = 0;
    int        failed = 0;
    bit        hung = 1'b0;

    always #5 ddr_ref_clk = ~ddr_ref_clk;

    slave_ddr3 #(
        .MEM_AW           (MEM_AW),
        .INIT_CYCLES      (INIT_CYCLES),
        .REFRESH_INTERVAL (150),
        .REFRESH_CYCLES   (8)
    ) UUT (.*);

    //////////////////// reporting
    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("[ERROR] test %0d %s expected %h got %h", tests + 1, name, exp, act);
        errors++;
    endtask

    task automatic report_timeout(string what);
        $display("test %0d timed out waiting for %s", tests + 1, what);
        errors++;
        hung = 1'b1;
    endtask

    task automatic log_test_result(string what);
        tests++;
        if (errors != errors_before) begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, what, errors - errors_before);
        end else begin
            $display("test %0d %s: ok", tests, what);
        end
        errors_before = errors;
    endtask

    //////////////////// bus tasks
    task automatic send_addr(bit is_rd);
        int n = 0;
        if (is_rd) rd_addr_valid = 1'b1;
        else wr_addr_valid = 1'b1;
        #1;
        while (!(is_rd ? rd_addr_ready : wr_addr_ready) && n < WAIT_LIMIT) begin
            @(negedge ddr_ref_clk);
            #1;
            n++;
        end
        if (!(is_rd ? rd_addr_ready : wr_addr_ready)) report_timeout("address ready");
        @(negedge ddr_ref_clk);
        wr_addr_valid = 1'b0;
        rd_addr_valid = 1'b0;
    endtask

    task automatic run_write(axi_id_t id, axi_addr_t addr, axi_len_t len, axi_burst_t burst,
                             axi_data_t base, axi_strb_t strb, axi_resp_t resp);
        int n;
        int word;
        bit done = 1'b0;
        wr_addr_id    = id;
        wr_addr       = addr;
        wr_addr_len   = len;
        wr_addr_burst = burst;
        send_addr(1'b0);
        for (int k = 0; k <= len && !hung; k++) begin
            wr_data       = base + k;  // beat k carries base + k
            wr_strb       = strb;
            wr_data_last  = (k == len);
            wr_data_valid = 1'b1;
            n = 0;
            #1;
            while (!wr_data_ready && n < WAIT_LIMIT) begin
                @(negedge ddr_ref_clk);
                #1;
                n++;
            end
            if (!wr_data_ready) begin
                report_timeout("write data ready");
            end else if (resp == RESP_OKAY) begin
                word = addr[31:2] + ((burst == BURST_INCR) ? k : 0);
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) shadow[word][8*b +: 8] = wr_data[8*b +: 8];
                end
            end
            @(negedge ddr_ref_clk);
        end
        wr_data_valid = 1'b0;
        n = 0;
        while (!done && !hung) begin
            wr_back_ready = ($urandom % 4) != 0;
            #1;
            done = wr_back_valid && wr_back_ready;
            if (done) begin
                if (wr_back_id !== id) report_mismatch("wr_back_id", id, wr_back_id);
                if (wr_back_resp !== resp) report_mismatch("wr_back_resp", resp, wr_back_resp);
            end else begin
                n++;
                if (n == WAIT_LIMIT) report_timeout("write response");
            end
            @(negedge ddr_ref_clk);
        end
        wr_back_ready = 1'b0;
    endtask

    task automatic run_read(axi_id_t id, axi_addr_t addr, axi_len_t len, axi_burst_t burst,
                            axi_resp_t resp, axi_data_t exp_base);
        int        n = 0;
        int        k = 0;
        int        word;
        axi_data_t expd;
        axi_data_t held_data;
        logic      held = 1'b0;
        rd_addr_id    = id;
        rd_addr       = addr;
        rd_addr_len   = len;
        rd_addr_burst = burst;
        send_addr(1'b1);
        while (k <= len && !hung) begin
            rd_data_ready = ($urandom % 4) != 0;
            #1;
            // a stalled beat must not move
            if (held && !rd_data_valid) report_mismatch("rd_data_valid", 1, rd_data_valid);
            if (held && rd_data !== held_data) report_mismatch("rd_data", held_data, rd_data);
            held      = rd_data_valid && !rd_data_ready;
            held_data = rd_data;
            if (rd_data_valid && rd_data_ready) begin
                word = addr[31:2] + ((burst == BURST_INCR) ? k : 0);
                if (resp != RESP_OKAY) expd = '0;
                else if (burst == BURST_FIXED) expd = exp_base;
                else expd = exp_base + k;
                if (rd_data !== expd) report_mismatch("rd_data", expd, rd_data);
                if (resp == RESP_OKAY && rd_data !== shadow[word]) begin
                    report_mismatch("rd_data against shadow", shadow[word], rd_data);
                end
                if (rd_data_resp !== resp) report_mismatch("rd_data_resp", resp, rd_data_resp);
                if (rd_data_last !== (k == len)) begin
                    report_mismatch("rd_data_last", k == len, rd_data_last);
                end
                if (rd_back_id !== id) report_mismatch("rd_back_id", id, rd_back_id);
                k++;
                n = 0;
            end else begin
                n++;
                if (n == WAIT_LIMIT) report_timeout("read data");
            end
            @(negedge ddr_ref_clk);
        end
        rd_data_ready = 1'b0;
    endtask

    //////////////////// main sequence
    initial begin
        int         fd;
        int         cycles = 0;
        string      line;
        logic [7:0] op;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_t burst;
        axi_data_t  base;
        axi_strb_t  strb;
        axi_resp_t  resp;
        axi_data_t  exp_base;
        void'($urandom(32'h3788_9339));
        for (int i = 0; i < (1 << MEM_AW); i++) shadow[i] = 'x;
        rst_n         = 1'b0;
        wr_addr_id    = '0;
        wr_addr       = '0;
        wr_addr_len   = '0;
        wr_addr_burst = BURST_INCR;
        wr_addr_valid = 1'b0;
        wr_data       = '0;
        wr_strb       = '0;
        wr_data_last  = 1'b0;
        wr_data_valid = 1'b0;
        wr_back_ready = 1'b0;
        rd_addr_id    = '0;
        rd_addr       = '0;
        rd_addr_len   = '0;
        rd_addr_burst = BURST_INCR;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b0;
        repeat (4) @(negedge ddr_ref_clk);
        rst_n = 1'b1;
        while (!init_done && cycles < WAIT_LIMIT) begin
            @(negedge ddr_ref_clk);
            cycles++;
            if (!init_done && (wr_addr_ready || rd_addr_ready)) begin
                $display("test 1 address ready went high before init_done");
                errors++;
            end
        end
        if (!init_done) report_timeout("init_done");
        else if (cycles != INIT_CYCLES) report_mismatch("init_done delay", INIT_CYCLES, cycles);
        log_test_result("start-up");
        fd = $fopen("ddr3_slave_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open ddr3_slave_golden.txt");
            errors++;
        end else begin
            while (!hung && !$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line[0] != "#" &&
                    $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, id, addr, len, burst,
                            base, strb, resp, exp_base) == 9) begin
                    if (op == "W") run_write(id, addr, len, burst, base, strb, resp);
                    else run_read(id, addr, len, burst, resp, exp_base);
                    log_test_result($sformatf("%c id %h addr %h len %0d burst %0d",
                                              op, id, addr, len + 1, burst));
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- slave_ddr3.sv
`timescale 1ns/1ps

module slave_ddr3 #(
    parameter int MEM_AW           = ddr_slave_pkg::MEM_AW_DEFAULT,
    parameter int INIT_CYCLES      = 20,
    parameter int REFRESH_INTERVAL = 150,
    parameter int REFRESH_CYCLES   = 8
) (
    input  logic                       ddr_ref_clk,
    input  logic                       rst_n,
    input  ddr_slave_pkg::axi_id_t     wr_addr_id,
    input  ddr_slave_pkg::axi_addr_t   wr_addr,
    input  ddr_slave_pkg::axi_len_t    wr_addr_len,
    input  ddr_slave_pkg::axi_burst_t  wr_addr_burst,
    input  logic                       wr_addr_valid,
    output logic                       wr_addr_ready,
    input  ddr_slave_pkg::axi_data_t   wr_data,
    input  ddr_slave_pkg::axi_strb_t   wr_strb,
    input  logic                       wr_data_last,  // beat count decides the end
    input  logic                       wr_data_valid,
    output logic                       wr_data_ready,
    output ddr_slave_pkg::axi_id_t     wr_back_id,
    output ddr_slave_pkg::axi_resp_t   wr_back_resp,
    output logic                       wr_back_valid,
    input  logic                       wr_back_ready,
    input  ddr_slave_pkg::axi_id_t     rd_addr_id,
    input  ddr_slave_pkg::axi_addr_t   rd_addr,
    input  ddr_slave_pkg::axi_len_t    rd_addr_len,
    input  ddr_slave_pkg::axi_burst_t  rd_addr_burst,
    input  logic                       rd_addr_valid,
    output logic                       rd_addr_ready,
    output ddr_slave_pkg::axi_id_t     rd_back_id,
    output ddr_slave_pkg::axi_data_t   rd_data,
    output ddr_slave_pkg::axi_resp_t   rd_data_resp,
    output logic                       rd_data_last,
    output logic                       rd_data_valid,
    input  logic                       rd_data_ready,
    output logic                       init_done
);

    import ddr_slave_pkg::*;

    logic              refresh_req;
    logic              refresh_ack;
    logic              agen_load;
    logic              agen_step;
    logic              agen_sel_rd;
    logic [MEM_AW-1:0] word_addr;
    logic              last_beat;
    logic              range_err;
    logic              burst_err;
    logic              mem_we;
    logic              mem_re;
    axi_data_t         mem_rdata;
    logic              rd_load;
    logic              rd_last;
    axi_resp_t         rd_resp;
    logic              rd_hold_busy;

    ddr_init_refresh_timer #(
        .INIT_CYCLES      (INIT_CYCLES),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) u_timer (
        .ddr_ref_clk, .rst_n,
        .refresh_ack, .init_done, .refresh_req
    );

    ddr_slave_fsm #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_fsm (
        .ddr_ref_clk, .rst_n, .init_done, .refresh_req, .refresh_ack,
        .wr_addr_id, .wr_addr_valid, .wr_addr_ready,
        .wr_data_valid, .wr_data_ready,
        .wr_back_id, .wr_back_resp, .wr_back_valid, .wr_back_ready,
        .rd_addr_id, .rd_addr_valid, .rd_addr_ready,
        .rd_back_id, .rd_data_ready, .rd_hold_busy,
        .agen_load, .agen_step, .agen_sel_rd,
        .last_beat, .range_err, .burst_err,
        .mem_we, .mem_re,
        .rd_load, .rd_last, .rd_resp
    );

    ddr_burst_addr_gen #(
        .MEM_AW (MEM_AW)
    ) u_agen (
        .ddr_ref_clk, .rst_n,
        .agen_load, .agen_step, .agen_sel_rd,
        .wr_addr, .rd_addr, .wr_addr_len, .rd_addr_len,
        .wr_addr_burst, .rd_addr_burst,
        .word_addr, .last_beat, .range_err, .burst_err
    );

    ddr_mem_array #(
        .MEM_AW (MEM_AW)
    ) u_mem (
        .ddr_ref_clk, .mem_we, .mem_re, .word_addr,
        .wr_data, .wr_strb, .mem_rdata
    );

    ddr_rd_data_path u_rd_path (
        .ddr_ref_clk, .rst_n,
        .rd_load, .rd_last, .rd_resp, .mem_rdata, .rd_data_ready,
        .rd_data, .rd_data_last, .rd_data_resp, .rd_data_valid,
        .rd_hold_busy
    );

endmodule

//--- ddr_rd_data_path.sv
`timescale 1ns/1ps

module ddr_rd_data_path (
    input  logic                      ddr_ref_clk,
    input  logic                      rst_n,
    input  logic                      rd_load,
    input  logic                      rd_last,
    input  ddr_slave_pkg::axi_resp_t  rd_resp,
    input  ddr_slave_pkg::axi_data_t  mem_rdata,
    input  logic                      rd_data_ready,
    output ddr_slave_pkg::axi_data_t  rd_data,
    output logic                      rd_data_last,
    output ddr_slave_pkg::axi_resp_t  rd_data_resp,
    output logic                      rd_data_valid,
    output logic                      rd_hold_busy
);

    import ddr_slave_pkg::*;

    logic      word_pend;  // word sitting in the array read register
    logic      pend_last;
    axi_resp_t pend_resp;
    logic      capture;

    assign capture      = word_pend && (!rd_data_valid || rd_data_ready);
    assign rd_hold_busy = rd_data_valid;

    always_ff @(posedge ddr_ref_clk) begin
        if (!rst_n) begin
            word_pend     <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            if (rd_load) begin
                word_pend <= 1'b1;
            end else if (capture) begin
                word_pend <= 1'b0;
            end
            if (capture) begin
                rd_data_valid <= 1'b1;  // next word replaces the taken one
            end else if (rd_data_ready) begin
                rd_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ddr_ref_clk) begin
        if (rd_load) begin
            pend_last <= rd_last;
            pend_resp <= rd_resp;
        end
        if (capture) begin
            rd_data      <= (pend_resp == RESP_OKAY) ? mem_rdata : '0;  // zero on error
            rd_data_last <= pend_last;
            rd_data_resp <= pend_resp;
        end
    end

endmodule

//--- ddr_mem_array.sv
`timescale 1ns/1ps

module ddr_mem_array #(
    parameter int MEM_AW = ddr_slave_pkg::MEM_AW_DEFAULT
) (
    input  logic                      ddr_ref_clk,
    input  logic                      mem_we,
    input  logic                      mem_re,
    input  logic [MEM_AW-1:0]         word_addr,
    input  ddr_slave_pkg::axi_data_t  wr_data,
    input  ddr_slave_pkg::axi_strb_t  wr_strb,
    output ddr_slave_pkg::axi_data_t  mem_rdata
);

    import ddr_slave_pkg::*;

    localparam int NUM_WORDS = 1 << MEM_AW;
    localparam int NUM_BYTES = $bits(axi_strb_t);

    axi_data_t mem [NUM_WORDS];  // stands in for the dram

    //////////////////// write port
    always_ff @(posedge ddr_ref_clk) begin
        if (mem_we) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[word_addr][8*b +: 8] <= wr_data[8*b +: 8];  // strobed bytes only
                end
            end
        end
    end

    //////////////////// read port
    always_ff @(posedge ddr_ref_clk) begin
        if (mem_re) begin
            mem_rdata <= mem[word_addr];  // held between reads
        end
    end

endmodule

//--- ddr_burst_addr_gen.sv
`timescale 1ns/1ps

module ddr_burst_addr_gen #(
    parameter int MEM_AW = ddr_slave_pkg::MEM_AW_DEFAULT
) (
    input  logic                       ddr_ref_clk,
    input  logic                       rst_n,
    input  logic                       agen_load,
    input  logic                       agen_step,
    input  logic                       agen_sel_rd,
    input  ddr_slave_pkg::axi_addr_t   wr_addr,
    input  ddr_slave_pkg::axi_addr_t   rd_addr,
    input  ddr_slave_pkg::axi_len_t    wr_addr_len,
    input  ddr_slave_pkg::axi_len_t    rd_addr_len,
    input  ddr_slave_pkg::axi_burst_t  wr_addr_burst,
    input  ddr_slave_pkg::axi_burst_t  rd_addr_burst,
    output logic [MEM_AW-1:0]          word_addr,
    output logic                       last_beat,
    output logic                       range_err,
    output logic                       burst_err
);

    import ddr_slave_pkg::*;

    localparam logic [30:0] TOP_WORD = 31'((1 << MEM_AW) - 1);

    axi_addr_t   ld_addr;
    axi_len_t    ld_len;
    axi_burst_t  ld_burst;
    logic [30:0] ld_end;  // last word touched by the burst
    axi_len_t    len_q;
    axi_len_t    beat_cnt;
    axi_burst_t  burst_q;

    assign ld_addr   = agen_sel_rd ? rd_addr : wr_addr;
    assign ld_len    = agen_sel_rd ? rd_addr_len : wr_addr_len;
    assign ld_burst  = agen_sel_rd ? rd_addr_burst : wr_addr_burst;
    assign ld_end    = {1'b0, ld_addr[31:2]} + 31'(ld_len);
    assign last_beat = (beat_cnt == len_q);

    always_ff @(posedge ddr_ref_clk) begin
        if (!rst_n) begin
            len_q     <= '0;
            beat_cnt  <= '0;
            burst_q   <= BURST_FIXED;
            range_err <= 1'b0;
            burst_err <= 1'b0;
        end else if (agen_load) begin
            len_q     <= ld_len;
            beat_cnt  <= '0;
            burst_q   <= ld_burst;
            range_err <= (ld_end > TOP_WORD);
            burst_err <= (ld_burst != BURST_FIXED) && (ld_burst != BURST_INCR);  // wrap, reserved
        end else if (agen_step) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge ddr_ref_clk) begin
        if (agen_load) begin
            word_addr <= ld_addr[MEM_AW+1:2];
        end else if (agen_step && burst_q == BURST_INCR) begin
            word_addr <= word_addr + 1'b1;  // fixed holds
        end
    end

endmodule

//--- ddr_slave_fsm.sv
`timescale 1ns/1ps

module ddr_slave_fsm #(
    parameter int REFRESH_CYCLES = 8
) (
    input  logic                      ddr_ref_clk,
    input  logic                      rst_n,
    input  logic                      init_done,
    input  logic                      refresh_req,
    output logic                      refresh_ack,
    input  ddr_slave_pkg::axi_id_t    wr_addr_id,
    input  logic                      wr_addr_valid,
    output logic                      wr_addr_ready,
    input  logic                      wr_data_valid,
    output logic                      wr_data_ready,
    output ddr_slave_pkg::axi_id_t    wr_back_id,
    output ddr_slave_pkg::axi_resp_t  wr_back_resp,
    output logic                      wr_back_valid,
    input  logic                      wr_back_ready,
    input  ddr_slave_pkg::axi_id_t    rd_addr_id,
    input  logic                      rd_addr_valid,
    output logic                      rd_addr_ready,
    output ddr_slave_pkg::axi_id_t    rd_back_id,
    input  logic                      rd_data_ready,
    input  logic                      rd_hold_busy,
    output logic                      agen_load,
    output logic                      agen_step,
    output logic                      agen_sel_rd,
    input  logic                      last_beat,
    input  logic                      range_err,
    input  logic                      burst_err,
    output logic                      mem_we,
    output logic                      mem_re,
    output logic                      rd_load,
    output logic                      rd_last,
    output ddr_slave_pkg::axi_resp_t  rd_resp
);

    import ddr_slave_pkg::*;

    localparam int RCW = $clog2(REFRESH_CYCLES + 1);

    mem_state_t     state;
    mem_state_t     state_nxt;
    logic [RCW-1:0] ref_cnt;
    logic [1:0]     rd_inflight;  // words loaded but not yet taken
    logic           rd_issue_done;
    logic           burst_bad;
    logic           wr_addr_fire;
    logic           rd_addr_fire;
    logic           wr_beat;
    logic           rd_take;

    assign burst_bad    = range_err | burst_err;
    assign wr_addr_fire = wr_addr_valid & wr_addr_ready;
    assign rd_addr_fire = rd_addr_valid & rd_addr_ready;
    assign wr_beat      = wr_data_valid & wr_data_ready;
    assign rd_take      = rd_hold_busy & rd_data_ready;
    assign agen_sel_rd  = rd_addr_fire;
    assign rd_last      = last_beat;
    assign rd_resp      = burst_bad ? RESP_SLVERR : RESP_OKAY;

    //////////////////// next state
    always_comb begin
        state_nxt     = state;
        wr_addr_ready = 1'b0;
        rd_addr_ready = 1'b0;
        wr_data_ready = 1'b0;
        wr_back_valid = 1'b0;
        agen_load     = 1'b0;
        agen_step     = 1'b0;
        mem_we        = 1'b0;
        mem_re        = 1'b0;
        rd_load       = 1'b0;
        case (state)
            INIT: begin
                if (init_done) state_nxt = IDLE;
            end
            IDLE: begin
                wr_addr_ready = !refresh_req;
                rd_addr_ready = !refresh_req && !wr_addr_valid;  // writes first
                if (refresh_req) begin
                    state_nxt = REFRESH;
                end else if (wr_addr_valid) begin
                    agen_load = 1'b1;
                    state_nxt = WR_BEAT;
                end else if (rd_addr_valid) begin
                    agen_load = 1'b1;
                    state_nxt = RD_START;
                end
            end
            REFRESH: begin
                if (ref_cnt == '0) state_nxt = IDLE;
            end
            WR_BEAT: begin
                wr_data_ready = 1'b1;
                if (wr_data_valid) begin
                    agen_step = 1'b1;
                    mem_we    = !burst_bad;  // bad bursts are drained
                    if (last_beat) state_nxt = WR_RESP;
                end
            end
            WR_RESP: begin
                wr_back_valid = 1'b1;
                if (wr_back_ready) state_nxt = IDLE;
            end
            RD_START: begin
                agen_step = 1'b1;
                rd_load   = 1'b1;
                mem_re    = !burst_bad;
                state_nxt = RD_BEAT;
            end
            RD_BEAT: begin
                if (!rd_issue_done && (!rd_hold_busy || rd_data_ready)) begin
                    agen_step = 1'b1;
                    rd_load   = 1'b1;
                    mem_re    = !burst_bad;
                end
                if (rd_issue_done && rd_take && rd_inflight == 2'd1) state_nxt = IDLE;
            end
            default: state_nxt = INIT;
        endcase
    end

    //////////////////// control state
    always_ff @(posedge ddr_ref_clk) begin
        if (!rst_n) begin
            state         <= INIT;
            refresh_ack   <= 1'b0;
            ref_cnt       <= '0;
            rd_inflight   <= '0;
            rd_issue_done <= 1'b0;
        end else begin
            state       <= state_nxt;
            refresh_ack <= (state == IDLE) && refresh_req;  // pulse on entry
            if (state == IDLE) begin
                ref_cnt <= RCW'(REFRESH_CYCLES - 1);
            end else if (state == REFRESH) begin
                ref_cnt <= ref_cnt - 1'b1;
            end
            case ({rd_load, rd_take})
                2'b10:   rd_inflight <= rd_inflight + 1'b1;
                2'b01:   rd_inflight <= rd_inflight - 1'b1;
                default: rd_inflight <= rd_inflight;
            endcase
            if (agen_load) begin
                rd_issue_done <= 1'b0;
            end else if (rd_load && last_beat) begin
                rd_issue_done <= 1'b1;
            end
        end
    end

    // ids and write response of the current burst
    always_ff @(posedge ddr_ref_clk) begin
        if (wr_addr_fire) wr_back_id <= wr_addr_id;
        if (rd_addr_fire) rd_back_id <= rd_addr_id;
        if (wr_beat && last_beat) wr_back_resp <= burst_bad ? RESP_SLVERR : RESP_OKAY;
    end

endmodule

//--- ddr_init_refresh_timer.sv
`timescale 1ns/1ps

module ddr_init_refresh_timer #(
    parameter int INIT_CYCLES      = 20,
    parameter int REFRESH_INTERVAL = 150
) (
    input  logic ddr_ref_clk,
    input  logic rst_n,
    input  logic refresh_ack,
    output logic init_done,
    output logic refresh_req
);

    localparam int MAX_CNT = (INIT_CYCLES > REFRESH_INTERVAL) ? INIT_CYCLES : REFRESH_INTERVAL;
    localparam int CW      = $clog2(MAX_CNT + 1);

    logic [CW-1:0] cnt;

    // one down counter shared by the init wait and the refresh interval
    always_ff @(posedge ddr_ref_clk) begin
        if (!rst_n) begin
            cnt         <= CW'(INIT_CYCLES - 1);
            init_done   <= 1'b0;
            refresh_req <= 1'b0;
        end else if (refresh_ack) begin
            cnt         <= CW'(REFRESH_INTERVAL - 1);  // restart interval
            refresh_req <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (!init_done) begin
            init_done <= 1'b1;
            cnt       <= CW'(REFRESH_INTERVAL - 1);
        end else begin
            refresh_req <= 1'b1;  // held until acked
        end
    end

endmodule

//--- ddr_slave_pkg.sv
package ddr_slave_pkg;

    //////////////////// bus widths
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;   // 2-bit master id padded to 4
    typedef logic [7:0]  axi_len_t;  // beats minus one
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    //////////////////// burst and response codes
    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_INCR  = 2'd1;
    localparam axi_burst_t BURST_WRAP  = 2'd2;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    //////////////////// controller
    typedef enum logic [2:0] {
        INIT     = 3'd0,
        IDLE     = 3'd1,
        REFRESH  = 3'd2,
        WR_BEAT  = 3'd3,
        WR_RESP  = 3'd4,
        RD_START = 3'd5,
        RD_BEAT  = 3'd6
    } mem_state_t;

    localparam int MEM_AW_DEFAULT = 10;  // 1024 words

endpackage
